// ==== project.f ====
cpu_pkg.sv
cpu_memctrl.sv
cpu_ctrl.sv
cpu_regs.sv
cpu_intctrl.sv
cpu_top.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu \
    -f project.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim \
    || exit 1

// ==== tb_cpu.sv ====
// directed testbench for cpu_top: memory model, program builder, six bus tests and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int    CLK_PERIOD  = 8;
    localparam int    N_TESTS     = 6;
    localparam int    TEST_CYCLES = 2000;
    localparam addr_t CODE_BASE   = 16'h1000; // reset vector target
    localparam addr_t IRQ_BASE    = 16'h2000;
    localparam addr_t NMI_BASE    = 16'h3000;
    localparam addr_t SENTINEL    = 16'h00FF; // last store of every program

    logic  clk = 1'b0;
    logic  rst;
    logic  halt;
    logic  irq;
    logic  nmi;
    byte_t din;
    byte_t dout;
    addr_t addr;
    logic  we;
    logic  is_op;

    byte_t       mem [0:65535];
    byte_t       ref_mem [0:65535]; // final image of the run without halt
    addr_t       wr_log [$];        // write addresses in bus order
    addr_t       org_ptr;           // program builder cursor
    logic [15:0] lfsr;
    logic        done;
    int          op_count;
    addr_t       first_op_addr;
    logic        irq_armed;
    logic        nmi_too;           // raise nmi together with irq
    logic        halt_armed;
    addr_t       irq_at;            // opcode address that triggers irq
    addr_t       clear_at;          // write address that drops irq and nmi
    addr_t       halt_at;
    addr_t       halt_addr;         // bus address frozen by halt
    int          halt_left;

    assign din = mem[addr]; // asynchronous read

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_top DUT (
        .clk, .rst, .halt, .irq, .nmi, .din,
        .addr, .dout, .we, .is_op
    );

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        stop_run();
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] st);
        return st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1); // galois, taps 16 14 13 11
    endfunction

    task automatic rand_byte(output byte_t b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            b    = {lfsr[0], b[7:1]}; // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int count_writes(input addr_t a);
        int n;
        n = 0;
        foreach (wr_log[i]) begin
            if (wr_log[i] == a) n++;
        end
        return n;
    endfunction

    function automatic int first_write(input addr_t a);
        foreach (wr_log[i]) begin
            if (wr_log[i] == a) return i;
        end
        return -1;
    endfunction

    task automatic check_mem(input addr_t a, input byte_t exp);
        assert (mem[a] == exp) else begin
            $display("[ERROR] mem[%h]: expected %h, got %h", a, exp, mem[a]);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t got);
        assert (got == exp) else begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_count(input addr_t a, input int exp);
        assert (count_writes(a) == exp) else begin
            $display("address %h written %0d times instead of %0d", a, count_writes(a), exp);
            stop_run();
        end
    endtask

    task automatic emit(input byte_t b);
        mem[org_ptr] = b;
        org_ptr      = org_ptr + 16'd1;
    endtask

    task automatic emit_word(input word_t w);
        emit(w[15:8]); // operands are big-endian
        emit(w[7:0]);
    endtask

    task automatic emit_finish();
        addr_t loop_at;
        emit(OP_LDX_IMM);
        emit_word(SENTINEL);
        emit(OP_STA_X);
        loop_at = org_ptr;
        emit(OP_JMP); // spin here until the next reset
        emit_word(loop_at);
    endtask

    task automatic set_vector(input addr_t v, input addr_t target);
        mem[v]         = target[15:8];
        mem[v + 16'd1] = target[7:0];
    endtask

    // reset goes high here and stays for 8 cycles in run_program
    task automatic begin_test();
        logic [16:0] i;
        @(negedge clk);
        rst        = 1'b1;
        halt       = 1'b0;
        irq        = 1'b0;
        nmi        = 1'b0;
        done       = 1'b0;
        op_count   = 0;
        irq_armed  = 1'b0;
        nmi_too    = 1'b0;
        halt_armed = 1'b0;
        halt_left  = 0;
        irq_at     = '0;
        halt_at    = '0;
        clear_at   = 16'hFFFF; // vector byte, never a store target
        wr_log.delete();
        for (i = '0; i < 17'h10000; i = i + 17'd1) begin
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hC3; // background, never executed
        end
        set_vector(VEC_RST, CODE_BASE);
        set_vector(VEC_IRQ, IRQ_BASE);
        set_vector(VEC_NMI, NMI_BASE);
        org_ptr = CODE_BASE;
    endtask

    // one clock, sampled and driven at negedge where the bus is stable
    task automatic step_cycle();
        @(negedge clk);
        if (halt_left > 0) begin
            check_addr("addr", halt_addr, addr);
            assert (!we) else begin
                $display("[ERROR] we: expected 0, got %h", we);
                stop_run();
            end
            halt_left--;
            if (halt_left == 0) halt = 1'b0;
        end else begin
            if (is_op) begin
                if (op_count == 0) first_op_addr = addr;
                op_count++;
                if (irq_armed && addr == irq_at) begin
                    irq       = 1'b1;
                    nmi       = nmi_too;
                    irq_armed = 1'b0;
                end
                if (halt_armed && addr == halt_at) begin
                    halt       = 1'b1;
                    halt_addr  = addr;
                    halt_left  = 20;
                    halt_armed = 1'b0;
                end
            end
            if (we) begin
                mem[addr] = dout; // store lands in its we cycle
                wr_log.push_back(addr);
                if (addr == clear_at) begin
                    irq = 1'b0;
                    nmi = 1'b0;
                end
                if (addr == SENTINEL) done = 1'b1;
            end
        end
    endtask

    task automatic run_program();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (!done) step_cycle();
    endtask

    // pushes v1 then v2, pulls them back into 0070 and 0071
    task automatic build_stack_prog(input byte_t v1, input byte_t v2, output addr_t psh2);
        emit(OP_LDA_IMM);
        emit(v1);
        emit(OP_PSHA);
        emit(OP_LDA_IMM);
        emit(v2);
        psh2 = org_ptr;
        emit(OP_PSHA);
        emit(OP_PULA);
        emit(OP_LDX_IMM);
        emit_word(16'h0070);
        emit(OP_STA_X);
        emit(OP_PULA);
        emit(OP_INCX);
        emit(OP_STA_X);
        emit_finish();
    endtask

    task automatic build_nop_main(input byte_t v);
        repeat (6) emit(OP_NOP); // interrupt window
        emit(OP_LDX_IMM);
        emit_word(16'h0080);
        emit(OP_LDA_IMM);
        emit(v);
        emit(OP_STA_X);
        emit_finish();
    endtask

    task automatic build_handler(input addr_t at, input addr_t mark_addr, input byte_t mark);
        org_ptr = at;
        emit(OP_LDX_IMM);
        emit_word(mark_addr);
        emit(OP_LDA_IMM);
        emit(mark);
        emit(OP_STA_X);
        emit(OP_RTI);
    endtask

    task automatic test_straight_line();
        byte_t v;
        begin_test();
        rand_byte(v);
        emit(OP_LDA_IMM);
        emit(v);
        emit(OP_LDX_IMM);
        emit_word(16'h0040);
        emit(OP_STA_X);
        emit(OP_INCX);
        emit(OP_STA_X);
        emit_finish();
        run_program();
        check_addr("addr at first is_op", CODE_BASE, first_op_addr); // FFFE word
        check_mem(16'h0040, v);
        check_mem(16'h0041, v);
    endtask

    task automatic test_indirect_jump();
        byte_t t;
        begin_test();
        rand_byte(t);
        mem[16'h0500] = t; // table entry
        emit(OP_LDX_IMM);
        emit_word(16'h0500);
        emit(OP_LDA_X);
        emit(OP_LDX_IMM);
        emit_word(16'h0060);
        emit(OP_STA_X);
        emit(OP_JMP);
        emit_word(org_ptr + 16'd6); // past operand and the 4-byte block
        emit(OP_LDX_IMM);
        emit_word(16'h0061);
        emit(OP_STA_X);
        emit_finish();
        run_program();
        check_mem(16'h0060, t);
        check_count(16'h0061, 0); // skipped store
    endtask

    task automatic test_stack();
        byte_t v1;
        byte_t v2;
        addr_t psh2;
        begin_test();
        rand_byte(v1);
        rand_byte(v2);
        build_stack_prog(v1, v2, psh2);
        run_program();
        check_mem(16'h0070, v2); // last in, first out
        check_mem(16'h0071, v1);
        check_mem(16'h01FF, v1);
        check_mem(16'h01FE, v2);
    endtask

    task automatic test_irq();
        byte_t v;
        byte_t mk;
        addr_t ret;
        begin_test();
        rand_byte(v);
        rand_byte(mk);
        build_nop_main(v);
        build_handler(IRQ_BASE, 16'h0090, mk);
        irq_at    = CODE_BASE + 16'd2;
        irq_armed = 1'b1;
        clear_at  = 16'h0090; // irq held until the handler stores
        run_program();
        ret = irq_at + 16'd1; // taken at the boundary after that NOP
        check_count(16'h0090, 1);
        check_mem(16'h0090, mk);
        check_mem(16'h01FF, ret[7:0]); // pushed first
        check_mem(16'h01FE, ret[15:8]);
        check_mem(16'h0080, v);
    endtask

    task automatic test_nmi_priority();
        byte_t v;
        byte_t m_nmi;
        byte_t m_irq;
        begin_test();
        rand_byte(v);
        rand_byte(m_nmi);
        rand_byte(m_irq);
        build_nop_main(v);
        build_handler(NMI_BASE, 16'h00A0, m_nmi);
        build_handler(IRQ_BASE, 16'h00A1, m_irq);
        irq_at    = CODE_BASE + 16'd2;
        irq_armed = 1'b1;
        nmi_too   = 1'b1;
        clear_at  = 16'h00A1;
        run_program();
        check_count(16'h00A0, 1);
        check_count(16'h00A1, 1);
        assert (first_write(16'h00A0) < first_write(16'h00A1)) else begin
            $display("IRQ handler stored its marker before the NMI handler");
            stop_run();
        end
        check_mem(16'h00A0, m_nmi);
        check_mem(16'h00A1, m_irq);
        check_mem(16'h0080, v);
    endtask

    task automatic test_halt();
        byte_t       v1;
        byte_t       v2;
        addr_t       psh2;
        logic [16:0] i;
        rand_byte(v1);
        rand_byte(v2);
        begin_test();
        build_stack_prog(v1, v2, psh2);
        run_program();
        ref_mem = mem; // reference run, no halt
        begin_test();
        build_stack_prog(v1, v2, psh2);
        halt_at    = psh2;
        halt_armed = 1'b1;
        run_program();
        assert (!halt_armed) else begin
            $display("halt was never applied during the program");
            stop_run();
        end
        for (i = '0; i < 17'h10000; i = i + 17'd1) begin
            assert (mem[i[15:0]] == ref_mem[i[15:0]]) else begin
                $display("[ERROR] mem[%h]: expected %h, got %h",
                         i[15:0], ref_mem[i[15:0]], mem[i[15:0]]);
                stop_run();
            end
        end
        check_mem(16'h0070, v2);
        check_mem(16'h0071, v1);
    endtask

    initial begin
        rst  = 1'b1;
        halt = 1'b0;
        irq  = 1'b0;
        nmi  = 1'b0;
        lfsr = 16'd93;
        test_straight_line();
        test_indirect_jump();
        test_stack();
        test_irq();
        test_nmi_priority();
        test_halt();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
// top of the 8-bit core, connects controller, sequencer, registers and interrupts to the memory bus
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  halt,
    input  wire logic  irq,
    input  wire logic  nmi,
    input  wire byte_t din,
    output addr_t      addr,
    output byte_t      dout,
    output logic       we,
    output logic       is_op
);

    // bus requests
    logic fetch, opd, memhi, addrx, stack_push, stack_pull, wrq;
    logic [1:0] psh_sel;
    // register loads
    logic ld_a, ld_x, ld_pc, inc_pc, inc_x, dec_s, inc_s;
    // interrupt handshake
    logic int_ack, rti_done, at_boundary, int_pending;
    logic busy, vec_done;
    intvec_t intvec;
    word_t data;
    word_t x;
    byte_t op, a;
    addr_t s, pc;

    cpu_memctrl u_memctrl (
        .clk, .rst, .halt, .pc, .x, .s, .a,
        .fetch, .opd, .memhi, .addrx, .stack_push, .stack_pull, .wrq,
        .psh_sel, .intvec, .din,
        .addr, .dout, .we, .data, .op, .is_op, .busy, .vec_done
    );

    cpu_ctrl u_ctrl (
        .clk, .rst, .halt, .op, .data, .busy, .is_op, .vec_done, .int_pending,
        .int_is_nmi (intvec[1]),
        .fetch, .opd, .memhi, .addrx, .stack_push, .stack_pull, .wrq, .psh_sel,
        .ld_a, .ld_x, .ld_pc, .inc_pc, .inc_x, .dec_s, .inc_s,
        .int_ack, .rti_done, .at_boundary
    );

    cpu_regs u_regs (
        .clk, .rst, .halt, .data,
        .ld_a, .ld_x, .ld_pc, .inc_pc, .inc_x, .dec_s, .inc_s,
        .a, .x, .s, .pc
    );

    cpu_intctrl u_intctrl (
        .clk, .rst, .halt, .irq, .nmi, .int_ack, .rti_done, .at_boundary,
        .intvec, .int_pending
    );

endmodule

`default_nettype wire

// ==== cpu_intctrl.sv ====
// interrupt unit: reset request, NMI edge latch and IRQ mask, offers a one-hot vector at boundaries
`timescale 1ns/1ps
`default_nettype none

module cpu_intctrl
    import cpu_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic halt,
    input  wire logic irq,
    input  wire logic nmi,
    input  wire logic int_ack,
    input  wire logic rti_done,
    input  wire logic at_boundary,
    output intvec_t   intvec,
    output logic      int_pending
);

    logic    nmi_q;    // previous nmi level
    logic    nmi_lat;  // edge seen, not yet taken
    logic    irq_mask;
    intvec_t sel_q;    // source chosen at ack, held until its vector goes out

    assign int_pending = nmi_lat | (irq & ~irq_mask); // nmi ignores mask
    assign intvec      = at_boundary ? sel_q : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nmi_q    <= 1'b0;
            nmi_lat  <= 1'b0;
            irq_mask <= 1'b0;
            sel_q    <= INT_RST; // reset vector pending
        end else if (!halt) begin
            nmi_q <= nmi;
            if (int_ack) begin
                sel_q    <= nmi_lat ? INT_NMI : INT_IRQ; // nmi wins
                irq_mask <= 1'b1;
            end else if (at_boundary) begin
                sel_q <= '0; // vector handed to memctrl
            end
            if (int_ack && nmi_lat) begin
                nmi_lat <= 1'b0;
            end
            if (nmi && !nmi_q) begin
                nmi_lat <= 1'b1; // a new edge beats the clear
            end
            if (rti_done) begin
                irq_mask <= 1'b0;
            end
        end
    end

    a_vec_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(intvec))
        else $error("intvec not one-hot");

endmodule

`default_nettype wire

// ==== cpu_regs.sv ====
// register file of the core: A, X, S and PC with load and step paths
`timescale 1ns/1ps
`default_nettype none

module cpu_regs
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  halt,
    input  wire word_t data,
    input  wire logic  ld_a,
    input  wire logic  ld_x,
    input  wire logic  ld_pc,
    input  wire logic  inc_pc,
    input  wire logic  inc_x,
    input  wire logic  dec_s,
    input  wire logic  inc_s,
    output byte_t      a,
    output word_t      x,
    output addr_t      s,
    output addr_t      pc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            x  <= '0;
            s  <= SP_INIT;
            pc <= '0;
        end else if (!halt) begin
            if (ld_a) begin
                a <= data[7:0]; // byte reads land in the low half
            end
            if (ld_x) begin
                x <= data;
            end else if (inc_x) begin
                x <= x + 16'd1;
            end
            // push and pull never overlap
            if (dec_s) begin
                s <= s - 16'd1;
            end else if (inc_s) begin
                s <= s + 16'd1;
            end
            if (ld_pc) begin
                pc <= data; // jump, vector or RTI
            end else if (inc_pc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    a_pc_src: assert property (@(posedge clk) disable iff (rst) !(ld_pc && inc_pc))
        else $error("pc load and increment together");

endmodule

`default_nettype wire

// ==== cpu_ctrl.sv ====
// control sequencer: fetches and decodes opcodes, then drives bus requests and register loads
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  halt,
    input  wire byte_t op,
    input  wire word_t data,
    input  wire logic  busy,
    input  wire logic  is_op,
    input  wire logic  vec_done,
    input  wire logic  int_pending,
    input  wire logic  int_is_nmi,
    output logic       fetch,
    output logic       opd,
    output logic       memhi,
    output logic       addrx,
    output logic       stack_push,
    output logic       stack_pull,
    output logic       wrq,
    output logic [1:0] psh_sel,
    output logic       ld_a,
    output logic       ld_x,
    output logic       ld_pc,
    output logic       inc_pc,
    output logic       inc_x,
    output logic       dec_s,
    output logic       inc_s,
    output logic       int_ack,
    output logic       rti_done,
    output logic       at_boundary
);

    ctrl_state_t state, state_nx;
    logic wait_q;   // one extra cycle for read data
    logic wait_set;
    logic vec_wait; // next boundary loads a vector instead of fetching
    logic ready;

    assign ready = !wait_q && !busy && !is_op;

    always_comb begin
        {fetch, opd, memhi, addrx, stack_push, stack_pull, wrq} = '0;
        {ld_a, ld_x, ld_pc, inc_pc, inc_x, dec_s, inc_s} = '0;
        {int_ack, rti_done, wait_set} = '0;
        psh_sel     = PSH_A;
        at_boundary = (state == FETCH);
        state_nx    = state;
        case (state)
            FETCH: begin
                if (vec_wait) begin
                    state_nx = VECTOR; // intctrl shows the vector now
                end else if (int_pending) begin
                    int_ack  = 1'b1;
                    state_nx = PUSH_LO;
                end else begin
                    fetch    = 1'b1;
                    inc_pc   = 1'b1;
                    wait_set = 1'b1;
                    state_nx = DECODE;
                end
            end
            DECODE: if (ready) begin
                state_nx = FETCH; // single cycle ops and NOP
                case (op)
                    OP_LDA_IMM: begin
                        opd      = 1'b1;
                        inc_pc   = 1'b1;
                        wait_set = 1'b1;
                        state_nx = OPERAND;
                    end
                    OP_LDX_IMM, OP_JMP: begin
                        opd      = 1'b1;
                        memhi    = 1'b1;
                        inc_pc   = 1'b1;
                        wait_set = 1'b1;
                        state_nx = OPERAND;
                    end
                    OP_LDA_X: begin
                        addrx    = 1'b1;
                        wait_set = 1'b1;
                        state_nx = EXEC;
                    end
                    OP_STA_X: begin
                        addrx = 1'b1;
                        wrq   = 1'b1;
                    end
                    OP_INCX: inc_x = 1'b1;
                    OP_PSHA: begin
                        stack_push = 1'b1;
                        dec_s      = 1'b1;
                    end
                    OP_PULA: begin
                        stack_pull = 1'b1;
                        inc_s      = 1'b1;
                        wait_set   = 1'b1;
                        state_nx   = EXEC;
                    end
                    OP_RTI: state_nx = PULL_HI;
                    OP_NOP: state_nx = FETCH;
                    default: state_nx = FETCH; // unknown opcodes act as NOP
                endcase
            end
            OPERAND: if (ready) begin
                if (op == OP_LDA_IMM) begin
                    ld_a = 1'b1;
                end else if (op == OP_LDX_IMM) begin
                    ld_x   = 1'b1;
                    inc_pc = 1'b1; // skip second operand byte
                end else begin
                    ld_pc = 1'b1;  // JMP
                end
                state_nx = FETCH;
            end
            EXEC: if (ready) begin
                ld_a     = 1'b1;
                state_nx = FETCH;
            end
            PUSH_LO: begin
                stack_push = 1'b1;
                psh_sel    = PSH_PCL;
                dec_s      = 1'b1;
                state_nx   = PUSH_HI;
            end
            PUSH_HI: begin
                stack_push = 1'b1;
                psh_sel    = PSH_PCH;
                dec_s      = 1'b1;
                state_nx   = FETCH;
            end
            PULL_HI: begin
                stack_pull = 1'b1; // word pull, PC high then low
                memhi      = 1'b1;
                inc_s      = 1'b1;
                wait_set   = 1'b1;
                state_nx   = PULL_LO;
            end
            PULL_LO: if (ready) begin
                ld_pc    = 1'b1;
                inc_s    = 1'b1;
                rti_done = 1'b1;
                state_nx = FETCH;
            end
            VECTOR: if (vec_done) begin
                ld_pc    = 1'b1;
                state_nx = FETCH;
            end
            default: state_nx = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FETCH;
            wait_q   <= 1'b0;
            vec_wait <= 1'b1; // reset vector first
        end else if (!halt) begin
            state <= state_nx;
            if (wait_set) begin
                wait_q <= 1'b1;
            end else if (!busy) begin
                wait_q <= 1'b0;
            end
            if (state == FETCH && vec_wait) begin
                vec_wait <= 1'b0;
            end else if (state == PUSH_HI) begin
                vec_wait <= 1'b1; // PC is on the stack
            end
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (rst)
        $onehot0({fetch, opd, addrx, stack_push, stack_pull}))
        else $error("more than one bus request");

    // NMI vector only offered once the return PC is stacked
    a_nmi_after_push: assert property (@(posedge clk) disable iff (rst)
        int_is_nmi |-> (at_boundary && vec_wait))
        else $error("NMI vector outside entry sequence");

    a_vec_target: assert property (@(posedge clk) disable iff (rst)
        (state == VECTOR && vec_done) |-> (data < VEC_IRQ))
        else $error("vector points into vector table");

endmodule

`default_nettype wire

// ==== cpu_memctrl.sv ====
// byte-wide memory controller: address source select, word assembly and write strobes for the core
`timescale 1ns/1ps
`default_nettype none

module cpu_memctrl
    import cpu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    halt,
    input  wire addr_t   pc,
    input  wire addr_t   x,
    input  wire addr_t   s,
    input  wire byte_t   a,
    input  wire logic    fetch,
    input  wire logic    opd,
    input  wire logic    memhi,
    input  wire logic    addrx,
    input  wire logic    stack_push,
    input  wire logic    stack_pull,
    input  wire logic    wrq,
    input  wire logic [1:0] psh_sel,
    input  wire intvec_t intvec,
    input  wire byte_t   din,
    output addr_t        addr,
    output byte_t        dout,
    output logic         we,
    output word_t        data,
    output byte_t        op,
    output logic         is_op,
    output logic         busy,
    output logic         vec_done
);

    logic  we_q;     // write strobe, one cycle after the request
    logic  rd_q;     // din is valid for us this cycle
    logic  vec_q;    // vector word in flight
    addr_t vec_addr;
    byte_t psh_byte;

    assign we = we_q & ~halt; // a frozen write waits for halt to drop

    always_comb begin
        if (intvec[2]) begin
            vec_addr = VEC_RST;
        end else if (intvec[1]) begin
            vec_addr = VEC_NMI;
        end else begin
            vec_addr = VEC_IRQ;
        end
    end

    always_comb begin
        case (psh_sel)
            PSH_PCL: psh_byte = pc[7:0];
            PSH_PCH: psh_byte = pc[15:8];
            default: psh_byte = a;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr     <= '0;
            we_q     <= 1'b0;
            busy     <= 1'b0;
            is_op    <= 1'b0;
            rd_q     <= 1'b0;
            vec_q    <= 1'b0;
            vec_done <= 1'b0;
        end else if (!halt) begin
            we_q     <= 1'b0; // single cycle strobes
            is_op    <= 1'b0;
            vec_done <= 1'b0;
            if (busy) begin
                addr <= addr + 16'd1; // high byte done, move to low byte
                busy <= 1'b0;         // rd_q stays set for the low byte
            end else begin
                rd_q <= 1'b0;
                if (rd_q && vec_q) begin
                    vec_done <= 1'b1; // low byte of vector lands now
                    vec_q    <= 1'b0;
                end
                // highest priority first
                if (|intvec) begin
                    addr  <= vec_addr;
                    busy  <= 1'b1; // vectors are always words
                    rd_q  <= 1'b1;
                    vec_q <= 1'b1;
                end else if (stack_push) begin
                    addr <= s - 16'd1; // pre-decrement push
                    we_q <= 1'b1;
                end else if (stack_pull) begin
                    addr <= s;
                    rd_q <= 1'b1;
                    busy <= memhi;
                end else if (addrx) begin
                    addr <= x;
                    we_q <= wrq;
                    rd_q <= ~wrq;
                    busy <= memhi & ~wrq;
                end else if (fetch || opd) begin
                    addr  <= pc;
                    rd_q  <= 1'b1;
                    is_op <= fetch;
                    busy  <= memhi;
                end
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (!halt) begin
            if (busy) begin
                data[15:8] <= din; // big-endian, high byte first
            end else if (rd_q) begin
                data[7:0] <= din;  // low half or plain byte
            end
            if (is_op) begin
                op <= din;
            end
            if (!busy && (stack_push || wrq)) begin
                dout <= psh_byte; // A unless pushing PC
            end
        end
    end

    // a write and a word read must never overlap on the bus
    a_no_we_busy: assert property (@(posedge clk) disable iff (rst) !(we && busy))
        else $error("we high during word read");

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
// shared widths, opcodes, vectors and sequencer states for the 8-bit core; import into each RTL file
`default_nettype none

package cpu_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0]   addr_t;   // memory address
    typedef logic [DATA_W-1:0]   byte_t;   // bus data byte
    typedef logic [2*DATA_W-1:0] word_t;   // register / operand value
    typedef logic [2:0]          intvec_t; // one-hot: {rst, nmi, irq}

    // opcode subset
    localparam byte_t OP_NOP     = 8'h12;
    localparam byte_t OP_LDA_IMM = 8'h86;
    localparam byte_t OP_LDX_IMM = 8'h8E; // 16-bit immediate
    localparam byte_t OP_LDA_X   = 8'hA6;
    localparam byte_t OP_STA_X   = 8'hA7;
    localparam byte_t OP_INCX    = 8'h30;
    localparam byte_t OP_PSHA    = 8'h34;
    localparam byte_t OP_PULA    = 8'h35;
    localparam byte_t OP_JMP     = 8'h7E; // 16-bit absolute target
    localparam byte_t OP_RTI     = 8'h3B;

    // vector table, big-endian words
    localparam addr_t VEC_IRQ = 16'hFFF8;
    localparam addr_t VEC_NMI = 16'hFFFC;
    localparam addr_t VEC_RST = 16'hFFFE;

    localparam addr_t SP_INIT = 16'h0200; // empty stack, first push lands at 01FF

    localparam intvec_t INT_IRQ = 3'b001;
    localparam intvec_t INT_NMI = 3'b010;
    localparam intvec_t INT_RST = 3'b100;

    // push data select
    localparam logic [1:0] PSH_A   = 2'd0;
    localparam logic [1:0] PSH_PCL = 2'd1;
    localparam logic [1:0] PSH_PCH = 2'd2;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        OPERAND, // waiting on an immediate / address operand
        EXEC,    // waiting on a data read at X or S
        PUSH_LO,
        PUSH_HI,
        PULL_LO,
        PULL_HI,
        VECTOR
    } ctrl_state_t;

endpackage

`default_nettype wire
